// ==== logic/fe_defs.svh ====
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// Datapath widths
`define PADDR_W 32
`define INSTR_W 32

// Instruction memory depth in words, as log2
`define IMEM_WORDS_LOG2 8

// Response delay bounds are 1 to this many cycles
`define IMEM_MAX_LAT 4

// Fetch starts here
`define RESET_PC 32'h0000_0000

`endif

// ==== logic/fe_pkg.sv ====
`include "fe_defs.svh"

package fe_pkg;

    typedef enum logic [2:0] {
        IDLE,
        REQ_IC,
        PDG_IC,       // Request out, waiting on memory
        PDG_STALL,    // Holding a response or waiting to refetch
        PDG_NUKE,
        HALT
    } t_fsm_fe;

    typedef enum logic [3:0] {
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        OP,
        OP_IMM,
        LUI,
        AUIPC,
        SYSTEM,
        ILLEGAL
    } t_rv_opcode;

    // Major opcode lives in the low seven bits
    function automatic t_rv_opcode classify_opcode(input logic [`INSTR_W-1:0] instr);
        t_rv_opcode cls;
        case (instr[6:0])
            7'b000_0011: cls = LOAD;
            7'b010_0011: cls = STORE;
            7'b110_0011: cls = BRANCH;
            7'b110_1111: cls = JAL;
            7'b110_0111: cls = JALR;
            7'b011_0011: cls = OP;
            7'b001_0011: cls = OP_IMM;
            7'b011_0111: cls = LUI;
            7'b001_0111: cls = AUIPC;
            7'b111_0011: cls = SYSTEM;
            default:     cls = ILLEGAL;
        endcase
        return cls;
    endfunction

endpackage

// ==== logic/fe_imem.sv ====
`include "fe_defs.svh"

module fe_imem (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_en,
    input  logic [`IMEM_WORDS_LOG2-1:0] load_addr,
    input  logic [`INSTR_W-1:0]         load_data,
    input  logic                        req_valid,
    input  logic [`PADDR_W-1:0]         req_addr,
    input  logic                        req_id,
    output logic                        rsp_valid,
    output logic [`PADDR_W-1:0]         rsp_pc,
    output logic [`INSTR_W-1:0]         rsp_instr,
    output logic                        rsp_id
);

    localparam int DEPTH = 1 << `IMEM_WORDS_LOG2;
    localparam int CNT_W = $clog2(`IMEM_MAX_LAT + 1);

    logic [`INSTR_W-1:0] mem [DEPTH];
    logic [7:0]          lfsr;
    logic                busy;          // One request in flight
    logic [CNT_W-1:0]    cnt;           // Cycles left before the response
    logic [`PADDR_W-1:0] addr_q;
    logic                id_q;

    // Program load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'ha5;
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            // Taps 8,6,5,4 give the full 255 state cycle
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (req_valid) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(lfsr % `IMEM_MAX_LAT);   // Delay minus one
            end else if (rsp_valid) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Request fields to echo back
    always_ff @(posedge clk) begin
        if (req_valid) begin
            addr_q <= req_addr;
            id_q   <= req_id;
        end
    end

    assign rsp_valid = busy & (cnt == '0);
    assign rsp_pc    = addr_q;
    assign rsp_id    = id_q;
    assign rsp_instr = mem[addr_q[`IMEM_WORDS_LOG2+1:2]];   // Word index from byte address

endmodule

// ==== logic/fe_ctl.sv ====
`include "fe_defs.svh"

module fe_ctl
    import fe_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    output logic                req_valid,
    output logic [`PADDR_W-1:0] req_addr,
    output logic                req_id,
    input  logic                rsp_valid,
    input  logic [`PADDR_W-1:0] rsp_pc,
    input  logic [`INSTR_W-1:0] rsp_instr,
    input  logic                rsp_id,
    input  logic                br_mispred_valid,
    input  logic [`PADDR_W-1:0] br_mispred_target,
    input  logic                nuke_valid,
    output logic                valid_fe1,
    output logic [`INSTR_W-1:0] instr_fe1,
    output logic [`PADDR_W-1:0] pc_fe1,
    input  logic                stall
);

    // PC wraps inside the instruction memory
    localparam logic [`PADDR_W-1:0] PC_MASK = `PADDR_W'((1 << (`IMEM_WORDS_LOG2 + 2)) - 1);

    t_fsm_fe             state;
    t_fsm_fe             state_nxt;
    logic [`PADDR_W-1:0] pc;
    logic                epoch;
    logic                nuke_pdg;
    logic                outstanding;
    logic                cap_valid;
    logic [`INSTR_W-1:0] cap_instr;
    logic [`PADDR_W-1:0] cap_pc;
    logic                rsp_ok;
    logic                halt_rsp;
    logic                hold_off;
    logic                accept;
    logic                capture;

    // Responses from an older epoch are dropped here
    assign rsp_ok   = rsp_valid & (rsp_id == epoch);
    assign halt_rsp = rsp_ok & (classify_opcode(rsp_instr) == SYSTEM);

    // Nothing goes out between a mispredict and its nuke
    assign hold_off = nuke_pdg | br_mispred_valid;

    assign valid_fe1 = ~hold_off & (((state == PDG_IC) & rsp_ok & ~halt_rsp)
                                  | ((state == PDG_STALL) & cap_valid));

    assign accept  = valid_fe1 & ~stall;
    assign capture = valid_fe1 & stall & (state == PDG_IC);   // Decode busy, park it

    // Stalled entries are reoffered from the capture copy
    assign instr_fe1 = (state == PDG_STALL) ? cap_instr : rsp_instr;
    assign pc_fe1    = (state == PDG_STALL) ? cap_pc : rsp_pc;

    // Refetch after a nuke waits for the old request to drain
    assign req_valid = ~hold_off & ((state == REQ_IC)
                                  | ((state == PDG_IC) & accept)
                                  | ((state == PDG_STALL) & ~stall & ~outstanding));
    assign req_addr  = pc;
    assign req_id    = epoch;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      state_nxt = REQ_IC;
            REQ_IC:    if (req_valid) state_nxt = PDG_IC;
            PDG_IC: begin
                if (halt_rsp) begin
                    state_nxt = HALT;           // SYSTEM word stops fetch
                end else if (capture) begin
                    state_nxt = PDG_STALL;
                end
            end
            PDG_STALL: if (req_valid) state_nxt = PDG_IC;
            PDG_NUKE:  if (nuke_valid) state_nxt = PDG_STALL;
            HALT:      state_nxt = HALT;
            default:   state_nxt = IDLE;
        endcase
        // Redirect wins from any state
        if (br_mispred_valid) begin
            state_nxt = PDG_NUKE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            pc          <= `RESET_PC;
            epoch       <= 1'b0;
            nuke_pdg    <= 1'b0;
            outstanding <= 1'b0;
            cap_valid   <= 1'b0;
        end else begin
            state <= state_nxt;

            if (br_mispred_valid) begin
                pc    <= br_mispred_target & PC_MASK;
                epoch <= ~epoch;                // Marks in-flight fetch as stale
            end else if (req_valid) begin
                pc <= (pc + 4) & PC_MASK;
            end

            nuke_pdg <= br_mispred_valid | (nuke_pdg & ~nuke_valid);

            if (req_valid) begin
                outstanding <= 1'b1;
            end else if (rsp_valid) begin
                outstanding <= 1'b0;            // Stale responses count too
            end

            if (br_mispred_valid) begin
                cap_valid <= 1'b0;
            end else if (capture) begin
                cap_valid <= 1'b1;
            end else if (accept & (state == PDG_STALL)) begin
                cap_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            cap_instr <= rsp_instr;
            cap_pc    <= rsp_pc;
        end
    end

endmodule

// ==== logic/fe_decode.sv ====
`include "fe_defs.svh"

module fe_decode
    import fe_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                valid_fe1,
    input  logic [`INSTR_W-1:0] instr_fe1,
    input  logic [`PADDR_W-1:0] pc_fe1,
    output logic                stall,
    input  logic                de_stall,
    input  logic                br_mispred_valid,
    output logic                valid_de,
    output logic [`INSTR_W-1:0] instr_de,
    output logic [`PADDR_W-1:0] pc_de,
    output t_rv_opcode          opcode_de
);

    logic accept;

    // Only a held entry pushes back on fetch
    assign stall  = valid_de & de_stall;
    assign accept = valid_fe1 & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_de <= 1'b0;
        end else if (br_mispred_valid) begin
            valid_de <= 1'b0;                   // Flush wrong-path entry
        end else if (!stall) begin
            valid_de <= valid_fe1;
        end
    end

    // Payload is frozen while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_de  <= instr_fe1;
            pc_de     <= pc_fe1;
            opcode_de <= classify_opcode(instr_fe1);   // Classified on the way in
        end
    end

endmodule

// ==== logic/fe_top.sv ====
`include "fe_defs.svh"

module fe_top
    import fe_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_en,
    input  logic [`IMEM_WORDS_LOG2-1:0] load_addr,
    input  logic [`INSTR_W-1:0]         load_data,
    input  logic                        br_mispred_valid,
    input  logic [`PADDR_W-1:0]         br_mispred_target,
    input  logic                        nuke_valid,
    input  logic                        de_stall,
    output logic                        valid_de,
    output logic [`INSTR_W-1:0]         instr_de,
    output logic [`PADDR_W-1:0]         pc_de,
    output t_rv_opcode                  opcode_de
);

    // Fetch to memory
    logic                req_valid;
    logic [`PADDR_W-1:0] req_addr;
    logic                req_id;

    // Memory back to fetch
    logic                rsp_valid;
    logic [`PADDR_W-1:0] rsp_pc;
    logic [`INSTR_W-1:0] rsp_instr;
    logic                rsp_id;

    // Fetch to decode
    logic                valid_fe1;
    logic [`INSTR_W-1:0] instr_fe1;
    logic [`PADDR_W-1:0] pc_fe1;
    logic                stall;

    fe_imem i_imem (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_id    (req_id),
        .rsp_valid (rsp_valid),
        .rsp_pc    (rsp_pc),
        .rsp_instr (rsp_instr),
        .rsp_id    (rsp_id)
    );

    fe_ctl i_ctl (
        .clk               (clk),
        .reset             (reset),
        .req_valid         (req_valid),
        .req_addr          (req_addr),
        .req_id            (req_id),
        .rsp_valid         (rsp_valid),
        .rsp_pc            (rsp_pc),
        .rsp_instr         (rsp_instr),
        .rsp_id            (rsp_id),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_target (br_mispred_target),
        .nuke_valid        (nuke_valid),
        .valid_fe1         (valid_fe1),
        .instr_fe1         (instr_fe1),
        .pc_fe1            (pc_fe1),
        .stall             (stall)
    );

    fe_decode i_decode (
        .clk              (clk),
        .reset            (reset),
        .valid_fe1        (valid_fe1),
        .instr_fe1        (instr_fe1),
        .pc_fe1           (pc_fe1),
        .stall            (stall),
        .de_stall         (de_stall),
        .br_mispred_valid (br_mispred_valid),
        .valid_de         (valid_de),
        .instr_de         (instr_de),
        .pc_de            (pc_de),
        .opcode_de        (opcode_de)
    );

endmodule

// ==== verification/fe_props.sv ====
`include "fe_defs.svh"

module fe_props
    import fe_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                br_mispred_valid,
    input logic                de_stall,
    input logic                valid_de,
    input logic [`INSTR_W-1:0] instr_de,
    input logic [`PADDR_W-1:0] pc_de,
    input t_rv_opcode          opcode_de,
    input t_fsm_fe             state
);

    // Decode entry frozen under stall
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        valid_de && de_stall && !br_mispred_valid |=>
            valid_de && $stable(instr_de) && $stable(pc_de) && $stable(opcode_de))
        else $error("decode outputs moved while stalled");

    a_flush_on_mispred: assert property (@(posedge clk) disable iff (reset)
        br_mispred_valid |=> !valid_de)
        else $error("valid_de high in the cycle after a mispredict");

    // Two quiet cycles once reset drops
    a_quiet_first: assert property (@(posedge clk) $fell(reset) |-> !valid_de)
        else $error("valid_de high in the first cycle after reset");
    a_quiet_second: assert property (@(posedge clk) $fell(reset) |=> !valid_de)
        else $error("valid_de high in the second cycle after reset");

    // Decode stays empty while fetch waits on the nuke
    a_quiet_in_nuke: assert property (@(posedge clk) disable iff (reset)
        state == PDG_NUKE |=> !valid_de)
        else $error("valid_de high after a cycle in PDG_NUKE");

endmodule

bind fe_top fe_props i_props (
    .clk              (clk),
    .reset            (reset),
    .br_mispred_valid (br_mispred_valid),
    .de_stall         (de_stall),
    .valid_de         (valid_de),
    .instr_de         (instr_de),
    .pc_de            (pc_de),
    .opcode_de        (opcode_de),
    .state            (i_ctl.state)
);

// ==== verification/fe_tb.sv ====
`include "fe_defs.svh"

module fe_tb
    import fe_pkg::*;
();

    localparam int NUM_DELIV  = 400;
    localparam int MAX_CYCLES = NUM_DELIV * 15 / 2;   // 7.5 cycles per delivery, halts included
    localparam int IDLE_LIMIT = 40;
    localparam int DEPTH      = 1 << `IMEM_WORDS_LOG2;
    localparam logic [`PADDR_W-1:0] PC_MASK = `PADDR_W'((1 << (`IMEM_WORDS_LOG2 + 2)) - 1);

    logic                        clk;
    logic                        reset;
    logic                        load_en;
    logic [`IMEM_WORDS_LOG2-1:0] load_addr;
    logic [`INSTR_W-1:0]         load_data;
    logic                        br_mispred_valid;
    logic [`PADDR_W-1:0]         br_mispred_target;
    logic                        nuke_valid;
    logic                        de_stall;
    logic                        valid_de;
    logic [`INSTR_W-1:0]         instr_de;
    logic [`PADDR_W-1:0]         pc_de;
    t_rv_opcode                  opcode_de;

    // Reference model
    logic [`INSTR_W-1:0] mem_model [DEPTH];
    t_rv_opcode          class_model [DEPTH];   // Class chosen when the word was made
    logic [`PADDR_W-1:0] last_pc;
    logic [`PADDR_W-1:0] target_q;
    logic                redirected;            // Mispredict since the last delivery
    logic                nuke_wait;
    logic                held_valid;
    logic [`INSTR_W-1:0] held_instr;
    logic [`PADDR_W-1:0] held_pc;
    t_rv_opcode          held_op;

    logic [31:0] rng;
    int          cycle;
    int          deliveries;
    int          idle;        // Cycles since the last delivery or redirect
    int          nuke_cnt;    // Cycles left until the nuke pulse

    fe_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .load_en           (load_en),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .br_mispred_valid  (br_mispred_valid),
        .br_mispred_target (br_mispred_target),
        .nuke_valid        (nuke_valid),
        .de_stall          (de_stall),
        .valid_de          (valid_de),
        .instr_de          (instr_de),
        .pc_de             (pc_de),
        .opcode_de         (opcode_de)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32 major opcodes
    function automatic logic [6:0] opcode_bits(input t_rv_opcode cls);
        case (cls)
            LOAD:    return 7'b000_0011;
            STORE:   return 7'b010_0011;
            BRANCH:  return 7'b110_0011;
            JAL:     return 7'b110_1111;
            JALR:    return 7'b110_0111;
            OP:      return 7'b011_0011;
            OP_IMM:  return 7'b001_0011;
            LUI:     return 7'b011_0111;
            AUIPC:   return 7'b001_0111;
            SYSTEM:  return 7'b111_0011;
            default: return 7'b111_1111;
        endcase
    endfunction

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input logic [`INSTR_W-1:0] got, input logic [`INSTR_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pc(input logic [`PADDR_W-1:0] got, input logic [`PADDR_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_opcode(input t_rv_opcode got, input t_rv_opcode exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            fail_run();
        end
    endtask

    // Random words with legal opcodes, SYSTEM at about 1 in 16
    task automatic load_program();
        t_rv_opcode          cls;
        logic [`INSTR_W-1:0] word;
        for (int i = 0; i < DEPTH; i++) begin
            rng = xorshift(rng);
            if (rng[3:0] == 4'h0) begin
                cls = SYSTEM;
            end else begin
                cls = t_rv_opcode'(rng[7:4] % 4'd9);
            end
            rng = xorshift(rng);
            word = {rng[31:7], opcode_bits(cls)};
            mem_model[i]   = word;
            class_model[i] = cls;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[`IMEM_WORDS_LOG2-1:0];
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Looks at the cycle that ends on this edge
    task automatic observe_cycle();
        logic [`PADDR_W-1:0]         exp_pc;
        logic [`IMEM_WORDS_LOG2-1:0] idx;
        if (held_valid) begin
            if (!valid_de) begin
                $display("Decode entry at PC %h was lost while stalled", held_pc);
                fail_run();
            end
            check_word(instr_de, held_instr, "stalled instruction");
            check_pc(pc_de, held_pc, "stalled PC");
            check_opcode(opcode_de, held_op, "stalled opcode");
        end
        held_valid = valid_de && de_stall && !br_mispred_valid;
        held_instr = instr_de;
        held_pc    = pc_de;
        held_op    = opcode_de;

        if (valid_de && !de_stall) begin
            if (nuke_wait) begin
                $display("Instruction at PC %h delivered while a nuke was pending", pc_de);
                fail_run();
            end
            exp_pc = redirected ? target_q : ((last_pc + 32'd4) & PC_MASK);
            idx    = pc_de[`IMEM_WORDS_LOG2+1:2];
            check_pc(pc_de, exp_pc, "delivered PC");
            check_word(instr_de, mem_model[idx], "delivered instruction");
            check_opcode(opcode_de, class_model[idx], "decoded opcode");
            if (class_model[idx] == SYSTEM) begin
                $display("SYSTEM word at PC %h reached decode", pc_de);
                fail_run();
            end
            last_pc    = pc_de;
            redirected = 1'b0;
            deliveries++;
            idle = 0;
        end else begin
            idle++;
        end

        // A delivery in the mispredict cycle is still from the old path
        if (br_mispred_valid) begin
            redirected = 1'b1;
            target_q   = br_mispred_target & PC_MASK;
            nuke_wait  = 1'b1;
            idle       = 0;
        end
        if (nuke_valid) begin
            nuke_wait = 1'b0;
        end
    endtask

    task automatic drive_cycle();
        rng = xorshift(rng);
        de_stall         <= (rng % 32'd10) < 32'd3;
        br_mispred_valid <= 1'b0;
        nuke_valid       <= 1'b0;
        if (nuke_cnt > 0) begin
            nuke_cnt--;
            if (nuke_cnt == 0) begin
                nuke_valid <= 1'b1;
            end
        end else begin
            rng = xorshift(rng);
            if (((rng % 32'd100) < 32'd2) || (idle >= IDLE_LIMIT)) begin
                br_mispred_valid <= 1'b1;
                rng = xorshift(rng);
                br_mispred_target <= {rng[31:2], 2'b00};   // Any aligned address, wraps in DUT
                rng = xorshift(rng);
                nuke_cnt = 1 + int'(rng % 32'd8);
            end
        end
    endtask

    initial begin
        reset             <= 1'b1;
        load_en           <= 1'b0;
        load_addr         <= '0;
        load_data         <= '0;
        br_mispred_valid  <= 1'b0;
        br_mispred_target <= '0;
        nuke_valid        <= 1'b0;
        de_stall          <= 1'b0;
        rng        = 32'h941d_ae70;
        last_pc    = '0;
        target_q   = `RESET_PC;    // Reset acts as the first redirect
        redirected = 1'b1;
        nuke_wait  = 1'b0;
        held_valid = 1'b0;
        cycle      = 0;
        deliveries = 0;
        idle       = 0;
        nuke_cnt   = 0;

        // Reset stays high through the load and for three cycles after it
        load_program();
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        while ((deliveries < NUM_DELIV) && (cycle < MAX_CYCLES)) begin
            @(posedge clk);
            cycle++;
            observe_cycle();
            drive_cycle();
        end

        if (deliveries >= NUM_DELIV) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d of %0d deliveries",
                     cycle, deliveries, NUM_DELIV);
            fail_run();
        end
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/fe_pkg.sv
logic/fe_imem.sv
logic/fe_ctl.sv
logic/fe_decode.sv
logic/fe_top.sv
verification/fe_props.sv
verification/fe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fe_tb -f tb.f -o fe_sim

./obj_dir/fe_sim 2>&1 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
